// File: fetch_pkg.sv
package fetch_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------
  localparam int XLEN = 32;
  localparam int ILEN = 32;

  // Fetch address and instruction word
  typedef logic [XLEN-1:0] addr_t;
  typedef logic [ILEN-1:0] instr_t;

  // Exception cause as returned by instruction memory
  typedef logic [3:0] except_code_t;

  // 2-bit saturating branch counter
  typedef logic [1:0] bpu_cnt_t;

  // ----------------------------------------
  // Front end / back end records
  // ----------------------------------------

  // Prediction made when the word was fetched
  typedef struct packed {
    addr_t pc;
    addr_t target;
    logic  taken;
  } prediction_t;

  // Branch outcome from the back end
  typedef struct packed {
    addr_t pc;
    addr_t target;
    logic  taken;
  } resolution_t;

  // One entry handed to the back end
  typedef struct packed {
    instr_t       instr;
    prediction_t  pred;
    logic         except_raised;
    except_code_t except_code;
  } issue_t;

endpackage

// File: fetch_pc_gen.sv
module fetch_pc_gen #(
  parameter fetch_pkg::addr_t BOOT_PC = '0
) (
  input  logic                   clk_i,
  input  logic                   reset_i,

  // Redirects from the back end
  input  logic                   mis_flush_i,
  input  fetch_pkg::resolution_t res_i,
  input  logic                   except_flush_i,
  input  fetch_pkg::addr_t       except_pc_i,

  // Handshake with the memory interface
  input  logic                   can_req_i,
  input  logic                   req_fire_i,

  // Predictor lookup
  input  fetch_pkg::prediction_t pred_i,
  output fetch_pkg::addr_t       lookup_pc_o,

  output logic                   req_valid_o,
  output logic                   flush_o,
  output logic                   bpu_clear_o
);

  import fetch_pkg::*;

  addr_t pc_q;
  addr_t mis_target;
  logic  run_q;

  // Held low through the reset cycle, high from then on
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      run_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
    end
  end

  // Corrected address after a mispredicted branch
  assign mis_target = res_i.taken ? res_i.target : res_i.pc + addr_t'(4);

  // ----------------------------------------
  // Program counter
  // ----------------------------------------
  // Exception redirect wins over misprediction
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pc_q <= BOOT_PC;
    end else if (except_flush_i) begin
      pc_q <= except_pc_i;
    end else if (mis_flush_i) begin
      pc_q <= mis_target;
    end else if (req_fire_i) begin
      pc_q <= pred_i.taken ? pred_i.target : pc_q + addr_t'(4);
    end
  end

  assign lookup_pc_o = pc_q;
  assign flush_o     = except_flush_i | mis_flush_i;
  assign bpu_clear_o = except_flush_i;

  // A pending request is dropped while a redirect is applied
  assign req_valid_o = run_q & can_req_i & ~flush_o;

  // Grant only ever follows our own request
  a_fire_needs_valid : assert property (
    @(posedge clk_i) disable iff (reset_i) req_fire_i |-> req_valid_o
  );

endmodule

// File: fetch_bpu.sv
module fetch_bpu #(
  parameter int BPU_BITS = 4
) (
  input  logic                   clk_i,
  input  logic                   reset_i,

  input  fetch_pkg::addr_t       lookup_pc_i,
  output fetch_pkg::prediction_t pred_o,

  input  logic                   res_valid_i,
  input  fetch_pkg::resolution_t res_i,
  input  logic                   clear_i
);

  import fetch_pkg::*;

  localparam int ENTRIES = 2 ** BPU_BITS;

  localparam bpu_cnt_t CNT_STRONG_NT = 2'd0;
  localparam bpu_cnt_t CNT_WEAK_NT   = 2'd1;
  localparam bpu_cnt_t CNT_WEAK_T    = 2'd2;
  localparam bpu_cnt_t CNT_STRONG_T  = 2'd3;

  typedef logic [BPU_BITS-1:0] idx_t;

  logic [ENTRIES-1:0] valid_q;
  bpu_cnt_t           cnt_q    [ENTRIES];
  addr_t              target_q [ENTRIES];

  idx_t look_idx;
  idx_t upd_idx;
  logic upd_en;

  // Word-aligned index bits
  assign look_idx = lookup_pc_i[BPU_BITS+1:2];
  assign upd_idx  = res_i.pc[BPU_BITS+1:2];
  assign upd_en   = res_valid_i & ~clear_i;

  // Lookup
  assign pred_o.pc     = lookup_pc_i;
  assign pred_o.target = target_q[look_idx];
  assign pred_o.taken  = valid_q[look_idx] & (cnt_q[look_idx] >= CNT_WEAK_T);

  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) begin
      valid_q <= '0;
    end else if (upd_en) begin
      valid_q[upd_idx] <= 1'b1;
    end
  end

  // ----------------------------------------
  // Counter and target update
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (upd_en) begin
      if (!valid_q[upd_idx]) begin
        // First sighting starts weak
        cnt_q[upd_idx]    <= res_i.taken ? CNT_WEAK_T : CNT_WEAK_NT;
        target_q[upd_idx] <= res_i.target;
      end else if (res_i.taken) begin
        if (cnt_q[upd_idx] != CNT_STRONG_T) begin
          cnt_q[upd_idx] <= cnt_q[upd_idx] + 2'd1;
        end
        target_q[upd_idx] <= res_i.target;
      end else if (cnt_q[upd_idx] != CNT_STRONG_NT) begin
        cnt_q[upd_idx] <= cnt_q[upd_idx] - 2'd1;
      end
    end
  end

endmodule

// File: fetch_memif.sv
module fetch_memif #(
  parameter int MEMIF_FIFO_DEPTH = 2
) (
  input  logic                    clk_i,
  input  logic                    reset_i,

  // From the PC generator
  input  logic                    req_valid_i,
  input  fetch_pkg::prediction_t  req_pred_i,
  output logic                    can_req_o,
  output logic                    req_fire_o,
  input  logic                    flush_i,

  // Instruction memory
  output logic                    instr_req_o,
  input  logic                    instr_gnt_i,
  input  logic                    instr_rvalid_i,
  output logic                    instr_rready_o,
  output fetch_pkg::addr_t        instr_addr_o,
  input  fetch_pkg::instr_t       instr_rdata_i,
  input  logic                    instr_except_raised_i,
  input  fetch_pkg::except_code_t instr_except_code_i,

  // Issue port
  output logic                    issue_valid_o,
  input  logic                    issue_ready_i,
  output fetch_pkg::issue_t       issue_o
);

  import fetch_pkg::*;

  localparam int PTR_W = (MEMIF_FIFO_DEPTH > 1) ? $clog2(MEMIF_FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(MEMIF_FIFO_DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [CNT_W-1:0] cnt_t;
  typedef enum logic {ST_LIVE, ST_DRAIN} drop_state_t;

  prediction_t fifo_q [MEMIF_FIFO_DEPTH];
  ptr_t        wr_ptr_q;
  ptr_t        rd_ptr_q;
  cnt_t        count_q;
  cnt_t        count_d;
  cnt_t        drop_cnt_q;
  drop_state_t state_q;
  logic        push;
  logic        pop;
  logic        drop;

  function automatic ptr_t ptr_inc(ptr_t p);
    if (p == ptr_t'(MEMIF_FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr_t'(p + 1'b1);
  endfunction

  // Request side
  assign instr_req_o  = req_valid_i;
  assign instr_addr_o = req_pred_i.pc;
  assign req_fire_o   = instr_req_o & instr_gnt_i;
  assign can_req_o    = (count_q != cnt_t'(MEMIF_FIFO_DEPTH));

  // Responses seen during a flush are stale as well
  assign drop           = flush_i | (state_q == ST_DRAIN);
  assign instr_rready_o = drop | issue_ready_i;
  assign push           = req_fire_o;
  assign pop            = instr_rvalid_i & instr_rready_o;
  assign count_d        = count_q + cnt_t'(push) - cnt_t'(pop);

  // ----------------------------------------
  // Outstanding request FIFO
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= req_pred_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
      count_q <= count_d;
    end
  end

  // ----------------------------------------
  // Drop FSM
  // ----------------------------------------
  // Everything still in flight at a flush belongs to the old path
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= ST_LIVE;
      drop_cnt_q <= '0;
    end else if (flush_i) begin
      state_q    <= (count_d != '0) ? ST_DRAIN : ST_LIVE;
      drop_cnt_q <= count_d;
    end else if (state_q == ST_DRAIN && pop) begin
      drop_cnt_q <= drop_cnt_q - 1'b1;
      if (drop_cnt_q == cnt_t'(1)) state_q <= ST_LIVE;
    end
  end

  // Response goes to issue with no register in between
  assign issue_valid_o         = instr_rvalid_i & ~drop;
  assign issue_o.instr         = instr_rdata_i;
  assign issue_o.pred          = fifo_q[rd_ptr_q];
  assign issue_o.except_raised = instr_except_raised_i;
  assign issue_o.except_code   = instr_except_code_i;

  a_no_overflow : assert property (
    @(posedge clk_i) disable iff (reset_i)
    (count_q == cnt_t'(MEMIF_FIFO_DEPTH)) |-> !req_fire_o
  );

  // Memory answers only what was granted
  a_rvalid_has_req : assert property (
    @(posedge clk_i) disable iff (reset_i) instr_rvalid_i |-> (count_q != '0)
  );

endmodule

// File: fetch_stage.sv
module fetch_stage #(
  parameter fetch_pkg::addr_t BOOT_PC          = '0,
  parameter int               BPU_BITS         = 4,
  parameter int               MEMIF_FIFO_DEPTH = 2
) (
  input  logic                    clk_i,
  input  logic                    reset_i,

  // Instruction memory interface
  output logic                    instr_req_o,
  input  logic                    instr_gnt_i,
  input  logic                    instr_rvalid_i,
  output logic                    instr_rready_o,
  output fetch_pkg::addr_t        instr_addr_o,
  input  fetch_pkg::instr_t       instr_rdata_i,
  input  logic                    instr_except_raised_i,
  input  fetch_pkg::except_code_t instr_except_code_i,

  // Issue to the back end
  output logic                    issue_valid_o,
  input  logic                    issue_ready_i,
  output fetch_pkg::issue_t       issue_o,

  // Resolutions and flushes from the back end
  input  logic                    res_valid_i,
  input  fetch_pkg::resolution_t  res_i,
  input  logic                    mis_flush_i,
  input  logic                    except_flush_i,
  input  fetch_pkg::addr_t        except_pc_i
);

  import fetch_pkg::*;

  addr_t       lookup_pc;
  prediction_t pred;
  logic        can_req;
  logic        req_valid;
  logic        req_fire;
  logic        flush;
  logic        bpu_clear;

  // ----------------------------------------
  // PC generation
  // ----------------------------------------
  fetch_pc_gen #(
    .BOOT_PC(BOOT_PC)
  ) i_pc_gen (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .mis_flush_i   (mis_flush_i),
    .res_i         (res_i),
    .except_flush_i(except_flush_i),
    .except_pc_i   (except_pc_i),
    .can_req_i     (can_req),
    .req_fire_i    (req_fire),
    .pred_i        (pred),
    .lookup_pc_o   (lookup_pc),
    .req_valid_o   (req_valid),
    .flush_o       (flush),
    .bpu_clear_o   (bpu_clear)
  );

  // Branch prediction
  fetch_bpu #(
    .BPU_BITS(BPU_BITS)
  ) i_bpu (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .lookup_pc_i(lookup_pc),
    .pred_o     (pred),
    .res_valid_i(res_valid_i),
    .res_i      (res_i),
    .clear_i    (bpu_clear)
  );

  // ----------------------------------------
  // Memory interface and issue
  // ----------------------------------------
  fetch_memif #(
    .MEMIF_FIFO_DEPTH(MEMIF_FIFO_DEPTH)
  ) i_memif (
    .clk_i                (clk_i),
    .reset_i              (reset_i),
    .req_valid_i          (req_valid),
    .req_pred_i           (pred),
    .can_req_o            (can_req),
    .req_fire_o           (req_fire),
    .flush_i              (flush),
    .instr_req_o          (instr_req_o),
    .instr_gnt_i          (instr_gnt_i),
    .instr_rvalid_i       (instr_rvalid_i),
    .instr_rready_o       (instr_rready_o),
    .instr_addr_o         (instr_addr_o),
    .instr_rdata_i        (instr_rdata_i),
    .instr_except_raised_i(instr_except_raised_i),
    .instr_except_code_i  (instr_except_code_i),
    .issue_valid_o        (issue_valid_o),
    .issue_ready_i        (issue_ready_i),
    .issue_o              (issue_o)
  );

endmodule

// File: tb_fetch_stage.sv
module tb_fetch_stage;

  import fetch_pkg::*;

  localparam addr_t       BOOT_PC        = 32'h0000_0100;
  localparam int          NUM_TESTS      = 6;
  localparam int          TIMEOUT_CYCLES = 400 * NUM_TESTS;
  localparam int          PRED_ENTRIES   = 16;
  localparam instr_t      WORD_MASK      = 32'hA5A5_0000;
  localparam logic [19:0] FAULT_PAGE     = 20'h00003;
  localparam addr_t       FAULT_PC       = 32'h0000_3000;
  localparam addr_t       TRAIN_PC       = 32'h0000_0208;
  localparam addr_t       TRAIN_TGT      = 32'h0000_0480;

  logic         clk_i;
  logic         reset_i;
  logic         instr_req_o;
  logic         instr_gnt_i;
  logic         instr_rvalid_i;
  logic         instr_rready_o;
  addr_t        instr_addr_o;
  instr_t       instr_rdata_i;
  logic         instr_except_raised_i;
  except_code_t instr_except_code_i;
  logic         issue_valid_o;
  logic         issue_ready_i;
  issue_t       issue_o;
  logic         res_valid_i;
  resolution_t  res_i;
  logic         mis_flush_i;
  logic         except_flush_i;
  addr_t        except_pc_i;

  integer seed;
  int     cycle_cnt;
  int     err_count;
  int     tests_failed;
  int     test_err_base;

  // Granted addresses and the cycle each may answer
  addr_t mem_addr_q [$];
  int    mem_due_q  [$];

  // Reference model
  logic        m_valid [PRED_ENTRIES];
  bpu_cnt_t    m_cnt   [PRED_ENTRIES];
  addr_t       m_tgt   [PRED_ENTRIES];
  prediction_t fl_q    [$];
  int          stale_cnt;
  addr_t       exp_pc;

  // Observed issue stream relative to the last flush
  int           issue_count;
  logic         first_req_seen;
  addr_t        first_req_pc;
  addr_t        first_issue_pc;
  prediction_t  prev_pred;
  logic         await_first;
  addr_t        first_after_pc;
  logic         p_seen;
  prediction_t  p_pred;
  logic         p_next_seen;
  addr_t        p_next_pc;
  logic         fault_seen;
  logic         fault_raised;
  except_code_t fault_code;

  fetch_stage #(
    .BOOT_PC(BOOT_PC)
  ) i_fetch_stage (
    .clk_i                (clk_i),
    .reset_i              (reset_i),
    .instr_req_o          (instr_req_o),
    .instr_gnt_i          (instr_gnt_i),
    .instr_rvalid_i       (instr_rvalid_i),
    .instr_rready_o       (instr_rready_o),
    .instr_addr_o         (instr_addr_o),
    .instr_rdata_i        (instr_rdata_i),
    .instr_except_raised_i(instr_except_raised_i),
    .instr_except_code_i  (instr_except_code_i),
    .issue_valid_o        (issue_valid_o),
    .issue_ready_i        (issue_ready_i),
    .issue_o              (issue_o),
    .res_valid_i          (res_valid_i),
    .res_i                (res_i),
    .mis_flush_i          (mis_flush_i),
    .except_flush_i       (except_flush_i),
    .except_pc_i          (except_pc_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the fetch stage stopped making progress", cycle_cnt);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------
  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      $display("ERROR t=%0t %s exp=%h act=%h", $time, name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_instr(input string name, input instr_t exp, input instr_t act);
    if (act !== exp) begin
      $display("ERROR t=%0t %s exp=%h act=%h", $time, name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_code(input string name, input except_code_t exp,
                            input except_code_t act);
    if (act !== exp) begin
      $display("ERROR t=%0t %s exp=%h act=%h", $time, name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR t=%0t %s exp=%b act=%b", $time, name, exp, act);
      err_count++;
    end
  endtask

  // Target only means something on a taken prediction
  task automatic check_pred(input string name, input prediction_t exp,
                            input prediction_t act);
    if (act.pc !== exp.pc || act.taken !== exp.taken ||
        (exp.taken && act.target !== exp.target)) begin
      $display("ERROR t=%0t %s exp=%h/%h/%b act=%h/%h/%b", $time, name,
               exp.pc, exp.target, exp.taken, act.pc, act.target, act.taken);
      err_count++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("t=%0t %s", $time, msg);
    err_count++;
  endtask

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  function automatic logic in_fault_page(addr_t a);
    return a[31:12] == FAULT_PAGE;
  endfunction

  function automatic resolution_t make_res(addr_t pc, addr_t target, logic taken);
    resolution_t r;
    r.pc     = pc;
    r.target = target;
    r.taken  = taken;
    return r;
  endfunction

  function automatic prediction_t model_predict(addr_t pc);
    prediction_t p;
    logic [3:0]  idx;
    idx      = pc[5:2];
    p.pc     = pc;
    p.target = m_tgt[idx];
    p.taken  = m_valid[idx] && (m_cnt[idx] >= 2'd2);
    return p;
  endfunction

  function automatic void model_update(resolution_t r);
    logic [3:0] idx;
    idx = r.pc[5:2];
    if (!m_valid[idx]) begin
      m_valid[idx] = 1'b1;
      m_cnt[idx]   = r.taken ? 2'd2 : 2'd1;
      m_tgt[idx]   = r.target;
    end else if (r.taken) begin
      if (m_cnt[idx] != 2'd3) m_cnt[idx] = m_cnt[idx] + 2'd1;
      m_tgt[idx] = r.target;
    end else if (m_cnt[idx] != 2'd0) begin
      m_cnt[idx] = m_cnt[idx] - 2'd1;
    end
  endfunction

  function automatic void clear_model_table();
    for (int i = 0; i < PRED_ENTRIES; i++) begin
      m_valid[i] = 1'b0;
    end
  endfunction

  task automatic reset_model();
    clear_model_table();
    for (int i = 0; i < PRED_ENTRIES; i++) begin
      m_cnt[i] = 2'd0;
      m_tgt[i] = '0;
    end
    fl_q.delete();
    mem_addr_q.delete();
    mem_due_q.delete();
    stale_cnt      = 0;
    exp_pc         = BOOT_PC;
    issue_count    = 0;
    first_req_seen = 1'b0;
    prev_pred      = '0;
    await_first    = 1'b0;
    p_seen         = 1'b0;
    p_next_seen    = 1'b0;
    fault_seen     = 1'b0;
  endtask

  // Live issue against the entry recorded at request time
  task automatic check_issue(input prediction_t ent);
    logic raised;
    raised = in_fault_page(ent.pc);
    check_pred("issue_o.pred", ent, issue_o.pred);
    check_instr("issue_o.instr", ent.pc ^ WORD_MASK, issue_o.instr);
    check_bit("issue_o.except_raised", raised, issue_o.except_raised);
    check_code("issue_o.except_code", raised ? 4'd5 : 4'd0, issue_o.except_code);
    if (issue_count == 0) first_issue_pc = issue_o.pred.pc;
    if (await_first) begin
      first_after_pc = issue_o.pred.pc;
      await_first    = 1'b0;
    end
    if (p_seen && !p_next_seen && prev_pred.pc == TRAIN_PC) begin
      p_next_pc   = issue_o.pred.pc;
      p_next_seen = 1'b1;
    end
    if (!p_seen && issue_o.pred.pc == TRAIN_PC) begin
      p_pred = issue_o.pred;
      p_seen = 1'b1;
    end
    if (!fault_seen && in_fault_page(issue_o.pred.pc)) begin
      fault_raised = issue_o.except_raised;
      fault_code   = issue_o.except_code;
      fault_seen   = 1'b1;
    end
    prev_pred = issue_o.pred;
    issue_count++;
  endtask

  // ----------------------------------------
  // Monitor sampled mid-cycle
  // ----------------------------------------
  always @(negedge clk_i) begin
    prediction_t ent;
    prediction_t p;
    logic        flushing;
    if (reset_i) begin
      if (instr_req_o !== 1'b0 || issue_valid_o !== 1'b0) begin
        report_failure("request or issue raised while in reset");
      end
      reset_model();
    end else begin
      flushing = mis_flush_i | except_flush_i;
      // Stale responses are taken at once and live ones wait for the back end
      if (instr_rvalid_i) begin
        check_bit("instr_rready_o", (flushing || stale_cnt > 0) ? 1'b1 : issue_ready_i,
                  instr_rready_o);
      end
      if (instr_rvalid_i && instr_rready_o) begin
        if (fl_q.size() == 0) begin
          report_failure("response consumed with no request outstanding");
        end else begin
          ent = fl_q.pop_front();
          if (flushing || stale_cnt > 0) begin
            if (stale_cnt > 0) stale_cnt--;
            if (issue_valid_o) begin
              report_failure($sformatf("instruction at pc %h from before a flush was issued",
                                       ent.pc));
            end
          end else if (!issue_valid_o) begin
            report_failure($sformatf("live response for pc %h was dropped", ent.pc));
          end else begin
            check_issue(ent);
          end
        end
        mem_addr_q.delete(0);
        mem_due_q.delete(0);
      end else if (issue_valid_o && !instr_rvalid_i) begin
        report_failure("issue valid without a memory response");
      end

      if (instr_req_o && flushing) report_failure("request raised in a flush cycle");
      if (instr_req_o && instr_gnt_i) begin
        check_addr("instr_addr_o", exp_pc, instr_addr_o);
        if (!first_req_seen) begin
          first_req_pc   = instr_addr_o;
          first_req_seen = 1'b1;
        end
        p = model_predict(exp_pc);
        fl_q.push_back(p);
        mem_addr_q.push_back(instr_addr_o);
        mem_due_q.push_back(cycle_cnt + 1 + ($unsigned($random(seed)) % 4));
        exp_pc = p.taken ? p.target : exp_pc + 32'd4;
      end

      // Exception redirect wins
      if (except_flush_i) begin
        exp_pc = except_pc_i;
        clear_model_table();
      end else if (mis_flush_i) begin
        exp_pc = res_i.taken ? res_i.target : res_i.pc + 32'd4;
      end
      if (flushing) begin
        stale_cnt   = fl_q.size();
        await_first = 1'b1;
        p_seen      = 1'b0;
        p_next_seen = 1'b0;
        fault_seen  = 1'b0;
      end
      if (res_valid_i && !except_flush_i) model_update(res_i);
    end
  end

  // Memory and back-end ready driven just after the edge
  always @(posedge clk_i) begin
    #2;
    instr_gnt_i   = ($random(seed) & 3) != 0;
    issue_ready_i = ($random(seed) & 3) != 0;
    if (mem_addr_q.size() > 0 && mem_due_q[0] <= cycle_cnt) begin
      instr_rvalid_i        = 1'b1;
      instr_rdata_i         = mem_addr_q[0] ^ WORD_MASK;
      instr_except_raised_i = in_fault_page(mem_addr_q[0]);
      instr_except_code_i   = in_fault_page(mem_addr_q[0]) ? 4'd5 : 4'd0;
    end else begin
      instr_rvalid_i        = 1'b0;
      instr_rdata_i         = '0;
      instr_except_raised_i = 1'b0;
      instr_except_code_i   = '0;
    end
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  task automatic pulse_backend(input logic rv, input resolution_t r, input logic mf,
                               input logic ef, input addr_t epc);
    @(posedge clk_i);
    #2;
    res_valid_i    = rv;
    res_i          = r;
    mis_flush_i    = mf;
    except_flush_i = ef;
    except_pc_i    = epc;
    @(posedge clk_i);
    #2;
    res_valid_i    = 1'b0;
    mis_flush_i    = 1'b0;
    except_flush_i = 1'b0;
  endtask

  task automatic wait_issues(input int n);
    while (issue_count < n) @(posedge clk_i);
  endtask

  task automatic end_test(input int num, input string name);
    if (err_count == test_err_base) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", num, name, err_count - test_err_base);
    end
    test_err_base = err_count;
  endtask

  initial begin
    seed                  = 32'hb859ed00;
    cycle_cnt             = 0;
    err_count             = 0;
    tests_failed          = 0;
    reset_i               = 1'b1;
    instr_gnt_i           = 1'b0;
    instr_rvalid_i        = 1'b0;
    instr_rdata_i         = '0;
    instr_except_raised_i = 1'b0;
    instr_except_code_i   = '0;
    issue_ready_i         = 1'b0;
    res_valid_i           = 1'b0;
    res_i                 = '0;
    mis_flush_i           = 1'b0;
    except_flush_i        = 1'b0;
    except_pc_i           = '0;
    repeat (16) @(posedge clk_i);
    #2;
    reset_i       = 1'b0;
    test_err_base = err_count;

    wait_issues(1);
    check_addr("instr_addr_o first request", BOOT_PC, first_req_pc);
    check_addr("issue_o.pred.pc first issue", BOOT_PC, first_issue_pc);
    end_test(1, "boot fetch");

    wait_issues(issue_count + 40);
    end_test(2, "sequential fetch");

    // Two taken outcomes, then steer fetch to just before the branch
    pulse_backend(1'b1, make_res(TRAIN_PC, TRAIN_TGT, 1'b1), 1'b0, 1'b0, '0);
    pulse_backend(1'b1, make_res(TRAIN_PC, TRAIN_TGT, 1'b1), 1'b0, 1'b0, '0);
    pulse_backend(1'b0, make_res(TRAIN_PC - 32'd8, '0, 1'b0), 1'b1, 1'b0, '0);
    while (!p_next_seen) @(posedge clk_i);
    check_bit("issue_o.pred.taken at trained pc", 1'b1, p_pred.taken);
    check_addr("issue_o.pred.target at trained pc", TRAIN_TGT, p_pred.target);
    check_addr("issue_o.pred.pc after trained pc", TRAIN_TGT, p_next_pc);
    end_test(3, "predictor training");

    pulse_backend(1'b1, make_res(TRAIN_PC, TRAIN_TGT, 1'b0), 1'b1, 1'b0, '0);
    while (await_first) @(posedge clk_i);
    check_addr("issue_o.pred.pc first after mis_flush", TRAIN_PC + 32'd4, first_after_pc);
    wait_issues(issue_count + 8);
    end_test(4, "misprediction flush");

    pulse_backend(1'b0, make_res('0, '0, 1'b0), 1'b0, 1'b1, TRAIN_PC - 32'd8);
    while (await_first) @(posedge clk_i);
    check_addr("issue_o.pred.pc first after except_flush", TRAIN_PC - 32'd8, first_after_pc);
    while (!p_seen) @(posedge clk_i);
    check_bit("issue_o.pred.taken after predictor clear", 1'b0, p_pred.taken);
    end_test(5, "exception flush");

    pulse_backend(1'b0, make_res('0, '0, 1'b0), 1'b0, 1'b1, FAULT_PC);
    while (!fault_seen) @(posedge clk_i);
    check_bit("issue_o.except_raised in faulting page", 1'b1, fault_raised);
    check_code("issue_o.except_code in faulting page", 4'd5, fault_code);
    end_test(6, "memory exception");

    $display("tests run %0d, failed %0d, errors %0d", NUM_TESTS, tests_failed, err_count);
    if (err_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: fetch_stage.f
fetch_pkg.sv
fetch_pc_gen.sv
fetch_bpu.sv
fetch_memif.sv
fetch_stage.sv
tb_fetch_stage.sv

// File: Makefile
# Verilator build and run of the fetch stage testbench

VERILATOR ?= verilator
TOP       ?= tb_fetch_stage
FILELIST  ?= fetch_stage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF '*** TEST PASSED ***' $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
